// File: verilog/memory_unit_defines.svh
`ifndef MEMORY_UNIT_DEFINES_SVH
`define MEMORY_UNIT_DEFINES_SVH

// Bus widths
`define MU_ADDR_WIDTH 16
`define MU_DATA_WIDTH 32

// Scratch RAM size as address bits
`define MU_RAM_DEPTH_LOG2 8

// ------------------------------------------------
// Address map (word addresses)
// ------------------------------------------------
`define MU_RAM_BASE           16'h0000
`define MU_SPI_DATA_ADDR      16'h0100
`define MU_SPI_CS_ADDR        16'h0101
`define MU_GPIO_ADDR          16'h0102
`define MU_TIMER_VALUE_ADDR   16'h0103
`define MU_TIMER_TRIGGER_ADDR 16'h0104

// SPI clock divider, system clocks per half SPI bit
`define MU_SPI_CLKS_PER_HALF_BIT 2

`endif

// File: verilog/memory_unit_pkg.sv
`include "memory_unit_defines.svh"

package memory_unit_pkg;

    typedef logic [`MU_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`MU_DATA_WIDTH-1:0]     word_t;
    typedef logic [7:0]                    byte_t;
    typedef logic [3:0]                    nibble_t;
    typedef logic [`MU_RAM_DEPTH_LOG2-1:0] ram_addr_t;

    // Decoded destination of a bus access
    typedef enum logic [2:0] {
        T_RAM,
        T_SPI_DATA,
        T_SPI_CS,
        T_GPIO,
        T_TIMER_VALUE,
        T_TIMER_TRIGGER,
        T_NONE
    } target_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_WAIT_SPI,
        S_RELEASE
    } seq_state_e;

    // CPU request as held on the bus
    typedef struct packed {
        addr_t addr;
        word_t data;
        logic  we;
    } bus_req_t;

endpackage

// File: verilog/bus_sequencer.sv
`timescale 1ns/100ps
`include "memory_unit_defines.svh"

module bus_sequencer import memory_unit_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_bus_start,
    input  bus_req_t i_bus_req,
    input  logic     i_spi_done,
    output bus_req_t o_req,
    output target_e  o_target,
    output logic     o_access,
    output logic     o_complete
);

    seq_state_e state;

    // Address map lookup, the only range check in the unit
    function automatic target_e decode(input addr_t addr);
        addr_t ram_offset;
        ram_offset = addr - `MU_RAM_BASE;
        if (ram_offset < addr_t'(1 << `MU_RAM_DEPTH_LOG2))
        begin
            return T_RAM;
        end
        case (addr)
            `MU_SPI_DATA_ADDR:      return T_SPI_DATA;
            `MU_SPI_CS_ADDR:        return T_SPI_CS;
            `MU_GPIO_ADDR:          return T_GPIO;
            `MU_TIMER_VALUE_ADDR:   return T_TIMER_VALUE;
            `MU_TIMER_TRIGGER_ADDR: return T_TIMER_TRIGGER;
            default:                return T_NONE;
        endcase
    endfunction

    // Request payload, captured when accepted
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && i_bus_start)
        begin
            o_req <= i_bus_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_IDLE;
            o_target   <= T_NONE;
            o_complete <= 1'b0;
        end
        else
        begin
            o_complete <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (i_bus_start)
                    begin
                        o_target <= decode(i_bus_req.addr);
                        state    <= S_ACCESS;
                    end
                end
                S_ACCESS:
                begin
                    // Only an SPI data write starts a transfer
                    if (o_target == T_SPI_DATA && o_req.we)
                    begin
                        state <= S_WAIT_SPI;
                    end
                    else
                    begin
                        o_complete <= 1'b1;
                        state      <= S_RELEASE;
                    end
                end
                S_WAIT_SPI:
                begin
                    if (i_spi_done)
                    begin
                        o_complete <= 1'b1;
                        state      <= S_RELEASE;
                    end
                end
                default:
                begin
                    // Hold off until the CPU drops start
                    if (!i_bus_start)
                    begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_access = (state == S_ACCESS);

endmodule

// File: verilog/scratch_ram.sv
`timescale 1ns/100ps
`include "memory_unit_defines.svh"

module scratch_ram (
    input  logic                          clk,
    input  logic                          i_we,
    input  logic [`MU_RAM_DEPTH_LOG2-1:0] i_addr,
    input  logic [`MU_DATA_WIDTH-1:0]     i_d,
    output logic [`MU_DATA_WIDTH-1:0]     o_q
);

    localparam int DEPTH = 1 << `MU_RAM_DEPTH_LOG2;

    logic [`MU_DATA_WIDTH-1:0] mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_d;
        end
    end

    // Registered read, old data on a write to the same word
    always_ff @(posedge clk)
    begin
        o_q <= mem[i_addr];
    end

endmodule

// File: verilog/spi_master.sv
`timescale 1ns/100ps

module spi_master import memory_unit_pkg::*; #(
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  i_start,
    input  byte_t i_byte,
    input  logic  i_miso,
    output logic  o_spi_clk,
    output logic  o_mosi,
    output logic  o_done,
    output byte_t o_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_HALF_BIT + 1);

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       half_cnt;
    byte_t            tx_shift;
    byte_t            rx_shift;

    // MSB first, bit leaves on the falling edge
    assign o_mosi = tx_shift[7];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            half_cnt  <= '0;
            o_spi_clk <= 1'b0;
            o_done    <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!busy)
            begin
                if (i_start)
                begin
                    busy     <= 1'b1;
                    clk_cnt  <= '0;
                    half_cnt <= '0;
                    tx_shift <= i_byte;
                end
            end
            else if (clk_cnt == CNT_W'(CLKS_PER_HALF_BIT - 1))
            begin
                clk_cnt   <= '0;
                o_spi_clk <= ~o_spi_clk;
                half_cnt  <= half_cnt + 4'd1;
                if (!o_spi_clk)
                begin
                    // Rising SPI edge samples MISO
                    rx_shift <= {rx_shift[6:0], i_miso};
                end
                else
                begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
                // Sixteenth half bit ends the byte
                if (half_cnt == 4'd15)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                    o_byte <= rx_shift;
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

endmodule

// File: verilog/os_timer.sv
`timescale 1ns/100ps

module os_timer import memory_unit_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  i_set,
    input  word_t i_value,
    input  logic  i_trigger,
    output logic  o_irq
);

    word_t reload;
    word_t count;
    logic  running;

    always_ff @(posedge clk)
    begin
        if (i_set)
        begin
            reload <= i_value;
        end
    end

    // One-shot countdown, stops after firing
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count   <= '0;
            running <= 1'b0;
            o_irq   <= 1'b0;
        end
        else
        begin
            o_irq <= 1'b0;
            if (i_trigger)
            begin
                count   <= reload;
                running <= 1'b1;
            end
            else if (running)
            begin
                if (count == '0)
                begin
                    o_irq   <= 1'b1;
                    running <= 1'b0;
                end
                else
                begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/io_registers.sv
`timescale 1ns/100ps

module io_registers import memory_unit_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_access,
    input  target_e  i_target,
    input  bus_req_t i_req,
    input  nibble_t  i_gpi,
    output logic     o_spi_cs,
    output nibble_t  o_gpo,
    output logic     o_timer_set,
    output logic     o_timer_trigger,
    output word_t    o_read_word
);

    logic wr;

    assign wr = i_access && i_req.we;

    // Chip select idles high, GPO comes from data bits 7:4
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_spi_cs <= 1'b1;
            o_gpo    <= '0;
        end
        else if (wr)
        begin
            if (i_target == T_SPI_CS)
            begin
                o_spi_cs <= i_req.data[0];
            end
            if (i_target == T_GPIO)
            begin
                o_gpo <= i_req.data[7:4];
            end
        end
    end

    // Timer registers are write only
    assign o_timer_set     = wr && (i_target == T_TIMER_VALUE);
    assign o_timer_trigger = wr && (i_target == T_TIMER_TRIGGER);

    always_comb
    begin
        case (i_target)
            T_SPI_CS: o_read_word = word_t'(o_spi_cs);
            T_GPIO:   o_read_word = word_t'({o_gpo, i_gpi});
            default:  o_read_word = '0;
        endcase
    end

endmodule

// File: verilog/read_return.sv
`timescale 1ns/100ps

module read_return import memory_unit_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    i_complete,
    input  target_e i_target,
    input  word_t   i_ram_q,
    input  byte_t   i_spi_byte,
    input  word_t   i_io_word,
    output word_t   o_bus_q,
    output logic    o_bus_done
);

    word_t sel_word;

    // Unmapped and timer addresses read as zero
    always_comb
    begin
        case (i_target)
            T_RAM:             sel_word = i_ram_q;
            T_SPI_DATA:        sel_word = word_t'(i_spi_byte);
            T_SPI_CS, T_GPIO:  sel_word = i_io_word;
            default:           sel_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_bus_q    <= '0;
            o_bus_done <= 1'b0;
        end
        else
        begin
            o_bus_done <= i_complete;
            if (i_complete)
            begin
                o_bus_q <= sel_word;
            end
        end
    end

endmodule

// File: verilog/memory_unit.sv
`timescale 1ns/100ps
`include "memory_unit_defines.svh"

module memory_unit import memory_unit_pkg::*; #(
    parameter int SPI_CLKS_PER_HALF_BIT = `MU_SPI_CLKS_PER_HALF_BIT
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t i_bus_req,
    input  logic     i_bus_start,
    output word_t    o_bus_q,
    output logic     o_bus_done,
    output logic     o_spi_clk,
    output logic     o_spi_mosi,
    input  logic     i_spi_miso,
    output logic     o_spi_cs,
    input  nibble_t  i_gpi,
    output nibble_t  o_gpo,
    output logic     o_timer_irq
);

    bus_req_t seq_req;
    target_e  seq_target;
    logic     seq_access;
    logic     seq_complete;
    word_t    ram_q;
    logic     ram_we;
    logic     spi_start;
    logic     spi_done;
    byte_t    spi_byte;
    logic     timer_set;
    logic     timer_trigger;
    word_t    io_word;

    // Target strobes
    assign ram_we    = seq_access && (seq_target == T_RAM) && seq_req.we;
    assign spi_start = seq_access && (seq_target == T_SPI_DATA) && seq_req.we;

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------
    bus_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .i_bus_start (i_bus_start),
        .i_bus_req   (i_bus_req),
        .i_spi_done  (spi_done),
        .o_req       (seq_req),
        .o_target    (seq_target),
        .o_access    (seq_access),
        .o_complete  (seq_complete)
    );

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    scratch_ram u_ram (
        .clk    (clk),
        .i_we   (ram_we),
        .i_addr (seq_req.addr[`MU_RAM_DEPTH_LOG2-1:0]),
        .i_d    (seq_req.data),
        .o_q    (ram_q)
    );

    spi_master #(
        .CLKS_PER_HALF_BIT (SPI_CLKS_PER_HALF_BIT)
    ) u_spi (
        .clk       (clk),
        .reset     (reset),
        .i_start   (spi_start),
        .i_byte    (seq_req.data[7:0]),
        .i_miso    (i_spi_miso),
        .o_spi_clk (o_spi_clk),
        .o_mosi    (o_spi_mosi),
        .o_done    (spi_done),
        .o_byte    (spi_byte)
    );

    io_registers u_io (
        .clk             (clk),
        .reset           (reset),
        .i_access        (seq_access),
        .i_target        (seq_target),
        .i_req           (seq_req),
        .i_gpi           (i_gpi),
        .o_spi_cs        (o_spi_cs),
        .o_gpo           (o_gpo),
        .o_timer_set     (timer_set),
        .o_timer_trigger (timer_trigger),
        .o_read_word     (io_word)
    );

    os_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .i_set     (timer_set),
        .i_value   (seq_req.data),
        .i_trigger (timer_trigger),
        .o_irq     (o_timer_irq)
    );

    // --------------------------------------------------
    // Read return
    // --------------------------------------------------
    read_return u_ret (
        .clk        (clk),
        .reset      (reset),
        .i_complete (seq_complete),
        .i_target   (seq_target),
        .i_ram_q    (ram_q),
        .i_spi_byte (spi_byte),
        .i_io_word  (io_word),
        .o_bus_q    (o_bus_q),
        .o_bus_done (o_bus_done)
    );

endmodule

// File: test/tb_memory_unit.sv
`timescale 1ns/100ps
`include "memory_unit_defines.svh"

module tb_memory_unit import memory_unit_pkg::*; ();

    // Done latency of register and RAM accesses, counting the accepting edge
    localparam int DONE_EDGES  = 3;
    localparam int BUS_TIMEOUT = 400;

    logic        clk;
    logic        reset;
    bus_req_t    i_bus_req;
    logic        i_bus_start;
    word_t       o_bus_q;
    logic        o_bus_done;
    logic        o_spi_clk;
    logic        o_spi_mosi;
    logic        i_spi_miso;
    logic        o_spi_cs;
    nibble_t     i_gpi;
    nibble_t     o_gpo;
    logic        o_timer_irq;
    logic [31:0] lfsr_state;
    logic        spi_clk_prev;
    byte_t       mosi_bits;
    int          spi_rises;

    memory_unit UUT (
        .clk         (clk),
        .reset       (reset),
        .i_bus_req   (i_bus_req),
        .i_bus_start (i_bus_start),
        .o_bus_q     (o_bus_q),
        .o_bus_done  (o_bus_done),
        .o_spi_clk   (o_spi_clk),
        .o_spi_mosi  (o_spi_mosi),
        .i_spi_miso  (i_spi_miso),
        .o_spi_cs    (o_spi_cs),
        .i_gpi       (i_gpi),
        .o_gpo       (o_gpo),
        .o_timer_irq (o_timer_irq)
    );

    // SPI loopback
    assign i_spi_miso = o_spi_mosi;

    always #10 clk = ~clk;

    // MOSI bits seen at each rising SPI clock
    always @(negedge clk)
    begin
        if (o_spi_clk && !spi_clk_prev)
        begin
            mosi_bits = {mosi_bits[6:0], o_spi_mosi};
            spi_rises++;
        end
        spi_clk_prev = o_spi_clk;
    end

    // --------------------------------------------------
    // Random data and error handling
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb)
        begin
            s = s ^ 32'h80200003;
        end
        return s;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_nibble(input string name, input nibble_t got, input nibble_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input string what, input int edges, input int exp);
        if (edges != exp)
        begin
            $display("%s finished %0d edges after start instead of %0d", what, edges, exp);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Bus tasks
    // --------------------------------------------------
    task automatic bus_access(input addr_t addr, input word_t data, input logic we,
                              output word_t q, output int edges);
        logic seen;
        @(negedge clk);
        // Previous done must have been a single pulse
        compare_bit("o_bus_done", o_bus_done, 1'b0);
        i_bus_req.addr = addr;
        i_bus_req.data = data;
        i_bus_req.we   = we;
        i_bus_start    = 1'b1;
        edges = 0;
        seen  = 1'b0;
        while (!seen)
        begin
            @(negedge clk);
            edges++;
            if (o_bus_done)
            begin
                seen = 1'b1;
            end
            else if (edges >= BUS_TIMEOUT)
            begin
                $display("Timeout waiting for o_bus_done at address 0x%04h", addr);
                abort_run();
            end
        end
        q = o_bus_q;
        i_bus_start = 1'b0;
    endtask

    task automatic bus_write(input addr_t addr, input word_t data, output int edges);
        word_t unused_q;
        bus_access(addr, data, 1'b1, unused_q, edges);
    endtask

    task automatic bus_read(input addr_t addr, output word_t q, output int edges);
        bus_access(addr, '0, 1'b0, q, edges);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_state_test();
        compare_bit("o_bus_done", o_bus_done, 1'b0);
        compare_bit("o_timer_irq", o_timer_irq, 1'b0);
        compare_bit("o_spi_clk", o_spi_clk, 1'b0);
        compare_bit("o_spi_cs", o_spi_cs, 1'b1);
        compare_nibble("o_gpo", o_gpo, 4'h0);
        compare_word("o_bus_q", o_bus_q, '0);
    endtask

    task automatic ram_test();
        addr_t addrs [8];
        word_t data [8];
        word_t rnd;
        word_t q;
        int    edges;
        for (int i = 0; i < 8; i++)
        begin
            // Low nibble from the index keeps the addresses distinct
            draw_bits(4, rnd);
            addrs[i] = `MU_RAM_BASE + addr_t'({rnd[3:0], i[3:0]});
            draw_bits(32, data[i]);
            bus_write(addrs[i], data[i], edges);
            check_latency("RAM write", edges, DONE_EDGES);
        end
        for (int i = 0; i < 8; i++)
        begin
            bus_read(addrs[i], q, edges);
            check_latency("RAM read", edges, DONE_EDGES);
            compare_word("o_bus_q", q, data[i]);
        end
    endtask

    task automatic gpio_test();
        word_t rnd;
        word_t data;
        word_t q;
        int    edges;
        for (int i = 0; i < 3; i++)
        begin
            draw_bits(4, rnd);
            @(negedge clk);
            i_gpi = rnd[3:0];
            draw_bits(32, data);
            bus_write(`MU_GPIO_ADDR, data, edges);
            check_latency("GPIO write", edges, DONE_EDGES);
            compare_nibble("o_gpo", o_gpo, data[7:4]);
            bus_read(`MU_GPIO_ADDR, q, edges);
            compare_word("o_bus_q", q, {24'h0, data[7:4], rnd[3:0]});
        end
    endtask

    task automatic spi_test();
        word_t rnd;
        word_t q;
        int    edges;
        // Drive chip select low and read it back
        bus_write(`MU_SPI_CS_ADDR, 32'hffff_fffe, edges);
        compare_bit("o_spi_cs", o_spi_cs, 1'b0);
        bus_read(`MU_SPI_CS_ADDR, q, edges);
        compare_word("o_bus_q", q, 32'h0);
        for (int i = 0; i < 3; i++)
        begin
            draw_bits(8, rnd);
            spi_rises = 0;
            bus_write(`MU_SPI_DATA_ADDR, rnd, edges);
            if (spi_rises != 8)
            begin
                $display("o_spi_clk rose %0d times during one byte instead of 8", spi_rises);
                abort_run();
            end
            // Mode 0 sends MSB first and idles low
            compare_byte("o_spi_mosi", mosi_bits, rnd[7:0]);
            compare_bit("o_spi_clk", o_spi_clk, 1'b0);
            // Loopback returns the byte just sent
            bus_read(`MU_SPI_DATA_ADDR, q, edges);
            compare_byte("o_bus_q[7:0]", q[7:0], rnd[7:0]);
            compare_word("o_bus_q", q, {24'h0, rnd[7:0]});
        end
        bus_write(`MU_SPI_CS_ADDR, 32'h1, edges);
        compare_bit("o_spi_cs", o_spi_cs, 1'b1);
        bus_read(`MU_SPI_CS_ADDR, q, edges);
        compare_word("o_bus_q", q, 32'h1);
    endtask

    task automatic timer_test();
        word_t rnd;
        int    n;
        int    edges;
        int    cycles;
        int    pulses;
        int    first;
        draw_bits(4, rnd);
        n = 10 + int'(rnd[3:0]);
        bus_write(`MU_TIMER_VALUE_ADDR, word_t'(n), edges);
        draw_bits(32, rnd);
        bus_write(`MU_TIMER_TRIGGER_ADDR, rnd, edges);
        cycles = 0;
        pulses = 0;
        first  = 0;
        // Watch well past the expected window to catch a second pulse
        while (cycles < n + 24)
        begin
            @(negedge clk);
            cycles++;
            if (o_timer_irq)
            begin
                pulses++;
                if (pulses == 1)
                begin
                    first = cycles;
                end
            end
        end
        if (pulses != 1)
        begin
            $display("o_timer_irq pulsed %0d times instead of once", pulses);
            abort_run();
        end
        if (first < n || first > n + 4)
        begin
            $display("o_timer_irq came %0d cycles after trigger, outside %0d to %0d",
                     first, n, n + 4);
            abort_run();
        end
    endtask

    task automatic unmapped_test();
        word_t rnd;
        word_t q;
        int    edges;
        draw_bits(15, rnd);
        bus_write(16'h8000 | rnd[15:0], 32'hdead_beef, edges);
        check_latency("Unmapped write", edges, DONE_EDGES);
        bus_read(16'h8000 | rnd[15:0], q, edges);
        check_latency("Unmapped read", edges, DONE_EDGES);
        compare_word("o_bus_q", q, 32'h0);
        bus_read(`MU_TIMER_VALUE_ADDR + 16'h2, q, edges);
        compare_word("o_bus_q", q, 32'h0);
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        i_bus_start  = 1'b0;
        i_bus_req    = '0;
        i_gpi        = '0;
        lfsr_state   = 32'h791d108a;
        spi_clk_prev = 1'b0;
        mosi_bits    = '0;
        spi_rises    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_state_test();
        ram_test();
        gpio_test();
        spi_test();
        timer_test();
        unmapped_test();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/memory_unit_pkg.sv
verilog/bus_sequencer.sv
verilog/scratch_ram.sv
verilog/spi_master.sv
verilog/os_timer.sv
verilog/io_registers.sv
verilog/read_return.sv
verilog/memory_unit.sv
test/tb_memory_unit.sv

// File: run.sh
#!/bin/sh
# Compile and run the memory unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_memory_unit -o sim_memory_unit

output=$(./obj_dir/sim_memory_unit 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi
